/* sim.f */
+incdir+include
design/dmm_reg_pkg.sv
design/dmm_acq_pkg.sv
design/acq_cfg_if.sv
design/acq_req_if.sv
design/spi_reg_bank.sv
design/sample_sequencer.sv
design/adc_mock.sv
design/output_mode_mux.sv
design/dmm_top.sv
dv/dmm_checker.sv
dv/tb_top.sv

/* dv/tb_top.sv */
// testbench top that clocks and resets the dmm core, drives spi frames and the trigger and runs the watchdog
`timescale 1ns/1ps
`default_nettype none
`include "dmm_settings.svh"

module tb_top;

  localparam int SPI_HALF   = 5;                  // clk cycles per sck half period
  localparam int RUN_TARGET = 10;                 // pulses before the trigger drops
  localparam int N_FRAMES   = 34;
  localparam int N_SAMPLES  = RUN_TARGET + 3;     // two in flight at stop plus one single shot
  localparam int PHASE_MAX  = 14;                 // precharge plus aperture with each below 8
  localparam int TIMEOUT_CYCLES =
    2 * (N_FRAMES * `DMM_SPI_BITS * 2 * SPI_HALF + N_SAMPLES * (PHASE_MAX + 4));

  logic        clk;
  logic        reset;
  logic        sck;
  logic        ss;
  logic        sdi;
  logic        sdo;
  logic        trigger;
  logic [3:0]  hw_flags;
  logic [3:0]  leds;
  logic [7:0]  monitor;
  logic [1:0]  pc_sw;
  logic [3:0]  azmux;
  logic        meas_complete;
  logic        spi_interrupt;
  logic [31:0] rng_state = 32'hd7d9;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                        // 8 ns period
  end

  dmm_top u_dmm_top (
    .clk (clk), .reset_i (reset),
    .sck_i (sck), .ss_i (ss), .sdi_i (sdi), .sdo_o (sdo),
    .trigger_i (trigger), .hw_flags_i (hw_flags),
    .leds_o (leds), .monitor_o (monitor), .pc_sw_o (pc_sw), .azmux_o (azmux),
    .meas_complete_o (meas_complete), .spi_interrupt_o (spi_interrupt)
  );

  dmm_checker u_dmm_checker (
    .clk (clk), .trigger_i (trigger), .hw_flags_i (hw_flags), .sdo_i (sdo),
    .leds_i (leds), .monitor_i (monitor), .pc_sw_i (pc_sw), .azmux_i (azmux),
    .meas_complete_i (meas_complete), .spi_interrupt_i (spi_interrupt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // spi host in mode 0 with msb first
  task automatic spi_frame(input logic wr, input logic [6:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {wr, addr, wdata};
    rdata = '0;
    ss <= 1'b0;
    repeat (SPI_HALF) @(posedge clk);
    for (int i = 39; i >= 0; i--) begin
      sck <= 1'b0;
      sdi <= frame[i];
      repeat (SPI_HALF) @(posedge clk);
      if (i < 32)
        rdata = {rdata[30:0], sdo};               // sample just before the rise
      sck <= 1'b1;
      repeat (SPI_HALF) @(posedge clk);
    end
    sck <= 1'b0;
    repeat (SPI_HALF) @(posedge clk);
    ss <= 1'b1;
    repeat (8) @(posedge clk);                    // write lands and pins follow
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] discard;
    spi_frame(1'b1, addr, data, discard);
    u_dmm_checker.note_write(addr, data);
  endtask

  task automatic spi_read(input logic [6:0] addr);
    logic [31:0] data;
    spi_frame(1'b0, addr, 32'h0, data);
    u_dmm_checker.check_read(addr, data);
  endtask

  task automatic wait_pulse();
    @(posedge clk);
    while (!meas_complete)
      @(posedge clk);
  endtask

  // sequencer stopped and adc back in idle
  task automatic wait_idle();
    @(posedge clk);
    while (leds[0] || monitor[3:2] != 2'b00)
      @(posedge clk);
    @(posedge clk);                               // checker has scored the last completion
  endtask

  initial begin
    reset    = 1'b1;
    sck      = 1'b0;
    ss       = 1'b1;
    sdi      = 1'b0;
    trigger  = 1'b0;
    hw_flags = 4'(next_rand());
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);

    u_dmm_checker.check_pins();
    spi_read(dmm_reg_pkg::ADDR_STATUS);
    u_dmm_checker.end_test("reset state");

    for (int a = 0; a <= 9; a++)
      if (a != dmm_reg_pkg::ADDR_STATUS)
        spi_write(7'(a), next_rand());
    for (int a = 0; a <= 9; a++)
      if (a != dmm_reg_pkg::ADDR_STATUS)
        spi_read(7'(a));
    u_dmm_checker.end_test("register masking");

    spi_write(dmm_reg_pkg::ADDR_MODE, dmm_reg_pkg::MODE_LO);
    u_dmm_checker.check_pins();
    spi_write(dmm_reg_pkg::ADDR_MODE, dmm_reg_pkg::MODE_HI);
    u_dmm_checker.check_pins();
    spi_write(dmm_reg_pkg::ADDR_DIRECT, next_rand());
    spi_write(dmm_reg_pkg::ADDR_MODE, dmm_reg_pkg::MODE_DIRECT);
    u_dmm_checker.check_pins();
    spi_write(dmm_reg_pkg::ADDR_MODE, 32'd5);     // spare code
    u_dmm_checker.check_pins();
    u_dmm_checker.end_test("pin modes");

    spi_write(dmm_reg_pkg::ADDR_PRECHARGE, next_rand() % 8);
    spi_write(dmm_reg_pkg::ADDR_APERTURE, next_rand() % 8);
    spi_write(dmm_reg_pkg::ADDR_SEQ_N, next_rand());
    for (int s = 0; s < `DMM_SEQ_MAX; s++)
      spi_write(7'(dmm_reg_pkg::ADDR_SEQ0 + s), next_rand());
    spi_write(dmm_reg_pkg::ADDR_MODE, dmm_reg_pkg::MODE_AZ_TEST);
    trigger <= 1'b1;
    repeat (RUN_TARGET) wait_pulse();
    trigger <= 1'b0;
    wait_idle();
    u_dmm_checker.end_test("azero sequence");

    spi_read(dmm_reg_pkg::ADDR_SAMPLE_LAST);
    u_dmm_checker.end_test("sample count");

    u_dmm_checker.check_irq(1'b0);
    trigger <= 1'b1;                              // single shot
    @(posedge clk);
    trigger <= 1'b0;
    wait_pulse();
    wait_idle();
    repeat (2) @(posedge clk);
    u_dmm_checker.check_irq(1'b1);
    spi_read(dmm_reg_pkg::ADDR_SAMPLE_LAST);
    u_dmm_checker.check_irq(1'b0);
    u_dmm_checker.end_test("interrupt flag");

    u_dmm_checker.report();
    if (u_dmm_checker.errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/dmm_checker.sv */
// watches the dmm top ports, holds the reference model and keeps per-test and total counts
`timescale 1ns/1ps
`default_nettype none
`include "dmm_settings.svh"

module dmm_checker (
  input wire        clk,
  input wire        trigger_i,
  input wire  [3:0] hw_flags_i,
  input wire        sdo_i,
  input wire  [3:0] leds_i,
  input wire  [7:0] monitor_i,
  input wire  [1:0] pc_sw_i,
  input wire  [3:0] azmux_i,
  input wire        meas_complete_i,
  input wire        spi_interrupt_i
);

  wire [`DMM_PIN_W-1:0] pins = {spi_interrupt_i, meas_complete_i, azmux_i, pc_sw_i,
                                monitor_i, leds_i};

  logic [31:0] regs [0:15];    // written values, already masked
  int          checks = 0;
  int          errors = 0;     // all failed checks of the run
  int          test_errors = 0;
  int          tests = 0;
  int          tests_failed = 0;
  int          run_pulses = 0; // pulses since the last trigger rise
  int          pulse_total = 0;
  logic [1:0]  last_idx = '0;
  logic [1:0]  pulse_idx;
  logic        trig_q = 1'b0;

  initial begin
    for (int a = 0; a < 16; a++)
      regs[a] = '0;            // register state after reset
  end

  //////////////////////////////////////////////////////////////////////
  // reference functions
  function automatic logic [31:0] field_mask(input logic [6:0] addr);
    case (addr)
      dmm_reg_pkg::ADDR_MODE:      return 32'h7;
      dmm_reg_pkg::ADDR_DIRECT:    return (32'd1 << `DMM_PIN_W) - 1;
      dmm_reg_pkg::ADDR_PRECHARGE,
      dmm_reg_pkg::ADDR_APERTURE:  return (32'd1 << `DMM_CNT_W) - 1;
      dmm_reg_pkg::ADDR_SEQ_N:     return 32'h3;
      dmm_reg_pkg::ADDR_SEQ0,
      dmm_reg_pkg::ADDR_SEQ1,
      dmm_reg_pkg::ADDR_SEQ2,
      dmm_reg_pkg::ADDR_SEQ3:      return 32'h3f;   // azmux over pc_sw
      default:                     return 32'h0;    // read only or unmapped
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [6:0] addr);
    case (addr)
      dmm_reg_pkg::ADDR_STATUS:      return {20'h0, hw_flags_i, `DMM_STATUS_MAGIC};
      dmm_reg_pkg::ADDR_SAMPLE_LAST: return {14'h0, pulse_total[15:0], last_idx};
      default:                       return regs[addr[3:0]] & field_mask(addr);
    endcase
  endfunction

  function automatic logic [`DMM_PIN_W-1:0] expected_pins(input logic [2:0] mode,
                                                          input logic [31:0] direct);
    case (mode)
      dmm_reg_pkg::MODE_DIRECT: return direct[`DMM_PIN_W-1:0];
      dmm_reg_pkg::MODE_HI:     return '1;
      default:                  return '0;          // lo and the spare codes
    endcase
  endfunction

  // table index of the n-th sample of a run
  function automatic logic [1:0] expected_idx(input int n);
    int len;
    len = regs[dmm_reg_pkg::ADDR_SEQ_N][1:0] + 1;
    return 2'(n % len);
  endfunction

  function automatic logic [5:0] expected_entry(input int n);
    logic [3:0] slot;
    slot = 4'(dmm_reg_pkg::ADDR_SEQ0) + expected_idx(n);
    return regs[slot][5:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // comparisons
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic note_write(input logic [6:0] addr, input logic [31:0] data);
    regs[addr[3:0]] = data & field_mask(addr);
  endtask

  task automatic check_read(input logic [6:0] addr, input logic [31:0] got);
    check_eq(got, expected_read(addr), $sformatf("read of register %0d", addr));
  endtask

  task automatic check_pins();
    check_eq(pins, expected_pins(regs[dmm_reg_pkg::ADDR_MODE][2:0],
             regs[dmm_reg_pkg::ADDR_DIRECT]), "pin vector");
    check_eq(sdo_i, 1'b0, "sdo low between frames");
  endtask

  task automatic check_irq(input logic exp);
    check_eq(spi_interrupt_i, exp, "spi interrupt pin");
  endtask

  // every completion seen on the pins in azero test mode
  always @(posedge clk) begin
    if (trigger_i && !trig_q)
      run_pulses = 0;                               // new run starts at entry 0
    trig_q = trigger_i;
    if (meas_complete_i && regs[dmm_reg_pkg::ADDR_MODE][2:0] == dmm_reg_pkg::MODE_AZ_TEST) begin
      pulse_idx = expected_idx(run_pulses);
      check_eq({azmux_i, pc_sw_i}, expected_entry(run_pulses), "switch entry at pulse");
      check_eq(monitor_i[1:0], pulse_idx, "monitor index at pulse");
      last_idx = pulse_idx;
      run_pulses++;
      pulse_total++;
    end
  end

  task automatic end_test(input string name);
    tests++;
    if (test_errors == 0)
      $display("test %s: pass", name);
    else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic report();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, tests_failed, checks, errors);
  endtask

endmodule

`default_nettype wire

/* design/dmm_top.sv */
// top level of the dmm control core, wires the stages to the board pins
`timescale 1ns/1ps
`default_nettype none

module dmm_top (
  input  wire        clk,
  input  wire        reset_i,
  // spi
  input  wire        sck_i,
  input  wire        ss_i,
  input  wire        sdi_i,
  output wire        sdo_o,
  input  wire        trigger_i,
  input  wire  [3:0] hw_flags_i,
  // board pins
  output wire  [3:0] leds_o,
  output wire  [7:0] monitor_o,
  output wire  [1:0] pc_sw_o,
  output wire  [3:0] azmux_o,
  output wire        meas_complete_o,
  output wire        spi_interrupt_o
);

  acq_cfg_if cfg_if ();
  acq_req_if req_if ();

  dmm_reg_pkg::mode_e      mode;
  dmm_reg_pkg::pin_vec_t   direct;
  dmm_reg_pkg::pin_vec_t   pins;
  dmm_acq_pkg::phase_e     phase;
  dmm_acq_pkg::seq_idx_t   cur_idx;
  dmm_acq_pkg::seq_idx_t   done_idx;
  logic [3:0]              adc_azmux;
  logic [1:0]              adc_pc_sw;
  logic                    meas_complete;
  logic                    spi_irq;
  logic                    running;

  spi_reg_bank u_spi_reg_bank (
    .clk             (clk),
    .reset_i         (reset_i),
    .sck_i           (sck_i),
    .ss_i            (ss_i),
    .sdi_i           (sdi_i),
    .hw_flags_i      (hw_flags_i),
    .meas_complete_i (meas_complete),
    .done_idx_i      (done_idx),
    .sdo_o           (sdo_o),
    .mode_o          (mode),
    .direct_o        (direct),
    .spi_interrupt_o (spi_irq),
    .cfg             (cfg_if.regs)
  );

  sample_sequencer u_sample_sequencer (
    .clk       (clk),
    .reset_i   (reset_i),
    .trigger_i (trigger_i),
    .cfg       (cfg_if.seq),
    .req       (req_if.src),
    .running_o (running)
  );

  adc_mock u_adc_mock (
    .clk             (clk),
    .reset_i         (reset_i),
    .cfg             (cfg_if.adc),
    .req             (req_if.dst),
    .azmux_o         (adc_azmux),
    .pc_sw_o         (adc_pc_sw),
    .phase_o         (phase),
    .cur_idx_o       (cur_idx),
    .meas_complete_o (meas_complete),   // fans out to bank and mux
    .done_idx_o      (done_idx)
  );

  output_mode_mux u_output_mode_mux (
    .clk             (clk),
    .reset_i         (reset_i),
    .mode_i          (mode),
    .direct_i        (direct),
    .azmux_i         (adc_azmux),
    .pc_sw_i         (adc_pc_sw),
    .phase_i         (phase),
    .cur_idx_i       (cur_idx),
    .meas_complete_i (meas_complete),
    .spi_interrupt_i (spi_irq),
    .running_i       (running),
    .pins_o          (pins)
  );

  // pin vector split onto the board ports, msb first
  assign {spi_interrupt_o, meas_complete_o, azmux_o, pc_sw_o, monitor_o, leds_o} = pins;

endmodule

`default_nettype wire

/* design/output_mode_mux.sv */
// registered pin vector select by mode, pins lag their source by one clk
`timescale 1ns/1ps
`default_nettype none

module output_mode_mux (
  input  wire                            clk,
  input  wire                            reset_i,
  input  wire  dmm_reg_pkg::mode_e       mode_i,
  input  wire  dmm_reg_pkg::pin_vec_t    direct_i,
  input  wire  [3:0]                     azmux_i,
  input  wire  [1:0]                     pc_sw_i,
  input  wire  dmm_acq_pkg::phase_e      phase_i,
  input  wire  dmm_acq_pkg::seq_idx_t    cur_idx_i,
  input  wire                            meas_complete_i,
  input  wire                            spi_interrupt_i,
  input  wire                            running_i,
  output dmm_reg_pkg::pin_vec_t          pins_o
);

  dmm_reg_pkg::pin_vec_t az_vec;

  // azero test with the mocked adc
  always_comb begin
    az_vec               = '0;
    az_vec.leds[0]       = running_i;
    az_vec.monitor[1:0]  = cur_idx_i;
    az_vec.monitor[2]    = (phase_i == dmm_acq_pkg::PH_PRECHARGE);
    az_vec.monitor[3]    = (phase_i == dmm_acq_pkg::PH_APERTURE);
    az_vec.pc_sw         = pc_sw_i;
    az_vec.azmux         = azmux_i;
    az_vec.meas_complete = meas_complete_i;
    az_vec.spi_interrupt = spi_interrupt_i;
  end

  always_ff @(posedge clk) begin
    if (reset_i)
      pins_o <= '0;
    else begin
      case (mode_i)
        dmm_reg_pkg::MODE_DIRECT:  pins_o <= direct_i;    // register drives all pins
        dmm_reg_pkg::MODE_LO:      pins_o <= '0;
        dmm_reg_pkg::MODE_HI:      pins_o <= '1;
        dmm_reg_pkg::MODE_AZ_TEST: pins_o <= az_vec;
        default:                   pins_o <= '0;          // unused modes park low
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/adc_mock.sv */
// mocked adc: applies the switch entry, times precharge then aperture, reports completion
`timescale 1ns/1ps
`default_nettype none
`include "dmm_settings.svh"

module adc_mock (
  input  wire                     clk,
  input  wire                     reset_i,
  acq_cfg_if.adc                  cfg,
  acq_req_if.dst                  req,
  output logic [3:0]              azmux_o,
  output logic [1:0]              pc_sw_o,
  output dmm_acq_pkg::phase_e     phase_o,
  output dmm_acq_pkg::seq_idx_t   cur_idx_o,
  output logic                    meas_complete_o,  // one cycle
  output dmm_acq_pkg::seq_idx_t   done_idx_o
);

  logic [`DMM_CNT_W-1:0] cnt_q;      // cycles left in phase, minus one
  logic [`DMM_CNT_W-1:0] pc_last;
  logic [`DMM_CNT_W-1:0] ap_last;

  // count of 0 behaves as 1
  assign pc_last = (cfg.precharge_cnt == '0) ? '0 : cfg.precharge_cnt - 1'b1;
  assign ap_last = (cfg.aperture_cnt == '0) ? '0 : cfg.aperture_cnt - 1'b1;

  assign req.ready = (phase_o == dmm_acq_pkg::PH_IDLE);
  wire take = req.valid & req.ready;

  //////////////////////////////////////////////////////////////////////
  // phase timer
  always_ff @(posedge clk) begin
    if (reset_i) begin
      phase_o         <= dmm_acq_pkg::PH_IDLE;
      cnt_q           <= '0;
      meas_complete_o <= 1'b0;
    end else begin
      meas_complete_o <= 1'b0;
      case (phase_o)
        dmm_acq_pkg::PH_IDLE: begin
          if (take) begin
            phase_o <= dmm_acq_pkg::PH_PRECHARGE;
            cnt_q   <= pc_last;
          end
        end
        dmm_acq_pkg::PH_PRECHARGE: begin
          if (cnt_q == '0) begin
            phase_o <= dmm_acq_pkg::PH_APERTURE;
            cnt_q   <= ap_last;
          end else
            cnt_q <= cnt_q - 1'b1;
        end
        dmm_acq_pkg::PH_APERTURE: begin
          if (cnt_q == '0) begin
            phase_o         <= dmm_acq_pkg::PH_IDLE;   // ready again with the pulse
            meas_complete_o <= 1'b1;
          end else
            cnt_q <= cnt_q - 1'b1;
        end
        default: phase_o <= dmm_acq_pkg::PH_IDLE;
      endcase
    end
  end

  // switches hold the last entry through idle, like the board
  always_ff @(posedge clk) begin
    if (reset_i) begin
      azmux_o   <= '0;
      pc_sw_o   <= '0;
      cur_idx_o <= '0;
    end else if (take) begin
      azmux_o   <= req.entry.azmux;
      pc_sw_o   <= req.entry.pc_sw;
      cur_idx_o <= req.idx;
    end
  end

  // finished index, stable after the pulse
  always_ff @(posedge clk) begin
    if (phase_o == dmm_acq_pkg::PH_APERTURE && cnt_q == '0)
      done_idx_o <= cur_idx_o;
  end

endmodule

`default_nettype wire

/* design/sample_sequencer.sv */
// walks the sequence table while triggered and presents sample requests to the adc mock
`timescale 1ns/1ps
`default_nettype none

module sample_sequencer (
  input  wire      clk,
  input  wire      reset_i,
  input  wire      trigger_i,      // level, arms the sequence
  acq_cfg_if.seq   cfg,
  acq_req_if.src   req,
  output logic     running_o
);

  dmm_acq_pkg::seq_idx_t   next_idx;    // table index of the next request
  logic                    valid_q;
  dmm_acq_pkg::seq_idx_t   idx_q;
  dmm_acq_pkg::seq_entry_t entry_q;

  // slot is free when nothing is held or the held one transfers now
  wire slot_free = !valid_q || req.ready;

  // control
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q  <= 1'b0;
      next_idx <= '0;
    end else if (slot_free) begin
      if (trigger_i) begin
        valid_q  <= 1'b1;
        // wrap after seq_n, also covers seq_n lowered mid run
        next_idx <= (next_idx >= cfg.seq_n) ? '0 : next_idx + 1'b1;
      end else begin
        valid_q  <= 1'b0;           // stop after the presented one went out
        next_idx <= '0;
      end
    end
  end

  // held request payload, frozen under back pressure
  always_ff @(posedge clk) begin
    if (slot_free && trigger_i) begin
      idx_q   <= next_idx;
      entry_q <= cfg.seq_table[next_idx];
    end
  end

  assign req.valid = valid_q;
  assign req.idx   = idx_q;
  assign req.entry = entry_q;

  assign running_o = valid_q | trigger_i;

endmodule

`default_nettype wire

/* design/spi_reg_bank.sv */
// spi slave oversampled on clk, holding config registers, status readback and the irq flag
`timescale 1ns/1ps
`default_nettype none
`include "dmm_settings.svh"

module spi_reg_bank (
  input  wire                              clk,
  input  wire                              reset_i,
  input  wire                              sck_i,
  input  wire                              ss_i,          // active low
  input  wire                              sdi_i,
  input  wire  [3:0]                       hw_flags_i,
  input  wire                              meas_complete_i,
  input  wire  dmm_acq_pkg::seq_idx_t      done_idx_i,
  output logic                             sdo_o,
  output dmm_reg_pkg::mode_e               mode_o,
  output dmm_reg_pkg::pin_vec_t            direct_o,
  output logic                             spi_interrupt_o,
  acq_cfg_if.regs                          cfg
);

  localparam int FRAME_BITS = `DMM_SPI_BITS;
  localparam int ADDR_BITS  = `DMM_ADDR_W;

  //////////////////////////////////////////////////////////////////////
  // synchronizers, two stages plus one of edge history
  logic [2:0] sck_q;
  logic [2:0] ss_q;
  logic [1:0] sdi_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sck_q <= '0;
      ss_q  <= '1;                 // deselected
      sdi_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      ss_q  <= {ss_q[1:0], ss_i};
      sdi_q <= {sdi_q[0], sdi_i};
    end
  end

  wire sck_rise = sck_q[1] & ~sck_q[2];
  wire sck_fall = ~sck_q[1] & sck_q[2];
  wire ss_idle  = ss_q[1];
  wire ss_rise  = ss_q[1] & ~ss_q[2];   // end of frame

  //////////////////////////////////////////////////////////////////////
  // frame shifting
  logic [FRAME_BITS-1:0]            rx_sr;
  logic [$clog2(FRAME_BITS+1)-1:0]  bit_cnt;
  dmm_reg_pkg::reg_t                tx_sr;       // read data out, msb first
  dmm_reg_pkg::reg_t                rd_data;
  dmm_reg_pkg::addr_t               rd_addr;
  dmm_reg_pkg::addr_t               frame_addr;

  wire shift_en = !ss_idle && sck_rise && (bit_cnt < FRAME_BITS);

  // address as it completes on the 8th rising edge
  assign rd_addr    = {rx_sr[ADDR_BITS-3:0], sdi_q[1]};
  assign frame_addr = rx_sr[FRAME_BITS-2 -: ADDR_BITS-1];

  wire frame_ok = ss_rise && (bit_cnt == FRAME_BITS);  // short frames dropped
  wire frame_wr = rx_sr[FRAME_BITS-1];

  always_ff @(posedge clk) begin
    if (reset_i || ss_idle) begin
      bit_cnt <= '0;
      sdo_o   <= 1'b0;
    end else begin
      if (shift_en)
        bit_cnt <= bit_cnt + 1'b1;
      if (sck_fall && bit_cnt >= ADDR_BITS)
        sdo_o <= tx_sr[`DMM_REG_W-1];     // host samples on the next rise
    end
  end

  always_ff @(posedge clk) begin
    if (shift_en)
      rx_sr <= {rx_sr[FRAME_BITS-2:0], sdi_q[1]};
    if (shift_en && bit_cnt == ADDR_BITS-1)
      tx_sr <= rd_data;                   // load readback at end of address byte
    else if (!ss_idle && sck_fall && bit_cnt >= ADDR_BITS)
      tx_sr <= {tx_sr[`DMM_REG_W-2:0], 1'b0};
  end

  //////////////////////////////////////////////////////////////////////
  // register storage
  logic [`DMM_CNT_W-1:0]                       precharge_q;
  logic [`DMM_CNT_W-1:0]                       aperture_q;
  dmm_acq_pkg::seq_idx_t                       seq_n_q;
  dmm_acq_pkg::seq_entry_t [`DMM_SEQ_MAX-1:0]  seq_q;
  logic [15:0]                                 sample_cnt;   // completed samples
  dmm_acq_pkg::seq_idx_t                       last_idx;

  wire [`DMM_REG_W-1:0] wdata = rx_sr[`DMM_REG_W-1:0];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      mode_o      <= dmm_reg_pkg::MODE_DIRECT;
      direct_o    <= '0;
      precharge_q <= '0;
      aperture_q  <= '0;
      seq_n_q     <= '0;
      seq_q       <= '0;
    end else if (frame_ok && frame_wr) begin
      case (frame_addr)                   // each field masked to its width
        dmm_reg_pkg::ADDR_MODE:      mode_o <= dmm_reg_pkg::mode_e'(wdata[2:0]);
        dmm_reg_pkg::ADDR_DIRECT:    direct_o <= wdata[`DMM_PIN_W-1:0];
        dmm_reg_pkg::ADDR_PRECHARGE: precharge_q <= wdata[`DMM_CNT_W-1:0];
        dmm_reg_pkg::ADDR_APERTURE:  aperture_q <= wdata[`DMM_CNT_W-1:0];
        dmm_reg_pkg::ADDR_SEQ_N:     seq_n_q <= wdata[$bits(seq_n_q)-1:0];
        dmm_reg_pkg::ADDR_SEQ0:      seq_q[0] <= wdata[5:0];
        dmm_reg_pkg::ADDR_SEQ1:      seq_q[1] <= wdata[5:0];
        dmm_reg_pkg::ADDR_SEQ2:      seq_q[2] <= wdata[5:0];
        dmm_reg_pkg::ADDR_SEQ3:      seq_q[3] <= wdata[5:0];
        default: ;                        // status and sample_last ignore writes
      endcase
    end
  end

  // sample bookkeeping and irq, a set beats a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sample_cnt      <= '0;
      last_idx        <= '0;
      spi_interrupt_o <= 1'b0;
    end else begin
      if (meas_complete_i) begin
        sample_cnt <= sample_cnt + 1'b1;
        last_idx   <= done_idx_i;
      end
      if (meas_complete_i)
        spi_interrupt_o <= 1'b1;
      else if (frame_ok && !frame_wr && frame_addr == dmm_reg_pkg::ADDR_SAMPLE_LAST)
        spi_interrupt_o <= 1'b0;
    end
  end

  // readback mux
  always_comb begin
    case (rd_addr)
      dmm_reg_pkg::ADDR_MODE:        rd_data = dmm_reg_pkg::reg_t'(mode_o);
      dmm_reg_pkg::ADDR_DIRECT:      rd_data = dmm_reg_pkg::reg_t'(direct_o);
      dmm_reg_pkg::ADDR_STATUS:      rd_data = {hw_flags_i, `DMM_STATUS_MAGIC};
      dmm_reg_pkg::ADDR_PRECHARGE:   rd_data = dmm_reg_pkg::reg_t'(precharge_q);
      dmm_reg_pkg::ADDR_APERTURE:    rd_data = dmm_reg_pkg::reg_t'(aperture_q);
      dmm_reg_pkg::ADDR_SEQ_N:       rd_data = dmm_reg_pkg::reg_t'(seq_n_q);
      dmm_reg_pkg::ADDR_SEQ0:        rd_data = dmm_reg_pkg::reg_t'(seq_q[0]);
      dmm_reg_pkg::ADDR_SEQ1:        rd_data = dmm_reg_pkg::reg_t'(seq_q[1]);
      dmm_reg_pkg::ADDR_SEQ2:        rd_data = dmm_reg_pkg::reg_t'(seq_q[2]);
      dmm_reg_pkg::ADDR_SEQ3:        rd_data = dmm_reg_pkg::reg_t'(seq_q[3]);
      dmm_reg_pkg::ADDR_SAMPLE_LAST: rd_data = {sample_cnt, last_idx};   // count in 17..2
      default:                       rd_data = '0;
    endcase
  end

  assign cfg.precharge_cnt = precharge_q;
  assign cfg.aperture_cnt  = aperture_q;
  assign cfg.seq_n         = seq_n_q;
  assign cfg.seq_table     = seq_q;

endmodule

`default_nettype wire

/* design/acq_req_if.sv */
// valid/ready sample requests from the sequencer to the adc mock
`timescale 1ns/1ps
`default_nettype none

interface acq_req_if;

  // transfer when valid and ready are both high,
  // idx and entry stay put until then
  logic                    valid;
  logic                    ready;
  dmm_acq_pkg::seq_idx_t   idx;
  dmm_acq_pkg::seq_entry_t entry;

  modport src (output valid, idx, entry, input ready);

  modport dst (input valid, idx, entry, output ready);

endinterface

`default_nettype wire

/* design/acq_cfg_if.sv */
// acquisition configuration from the register bank to the sequencer and the adc mock
`timescale 1ns/1ps
`default_nettype none
`include "dmm_settings.svh"

interface acq_cfg_if;

  logic [`DMM_CNT_W-1:0]  precharge_cnt;     // clk cycles, 0 acts as 1
  logic [`DMM_CNT_W-1:0]  aperture_cnt;
  dmm_acq_pkg::seq_idx_t  seq_n;             // last table index used

  dmm_acq_pkg::seq_entry_t [`DMM_SEQ_MAX-1:0] seq_table;

  modport regs (
    output precharge_cnt, aperture_cnt, seq_n, seq_table
  );

  modport seq (input seq_n, seq_table);

  modport adc (input precharge_cnt, aperture_cnt);

endinterface

`default_nettype wire

/* design/dmm_acq_pkg.sv */
// acquisition types: sequence table entry, table index and adc phase encoding
`default_nettype none
`include "dmm_settings.svh"

package dmm_acq_pkg;

  typedef logic [$clog2(`DMM_SEQ_MAX)-1:0] seq_idx_t;

  // low 6 bits of each seq register
  typedef struct packed {
    logic [3:0] azmux;   // azero mux select
    logic [1:0] pc_sw;   // precharge switches
  } seq_entry_t;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_PRECHARGE,
    PH_APERTURE
  } phase_e;

endpackage

`default_nettype wire

/* design/dmm_reg_pkg.sv */
// register map and register field types shared by the spi bank and the pin mux
`default_nettype none
`include "dmm_settings.svh"

package dmm_reg_pkg;

  typedef logic [`DMM_REG_W-1:0]  reg_t;
  typedef logic [`DMM_ADDR_W-2:0] addr_t;     // write flag stripped

  //////////////////////////////////////////////////////////////////////
  // register map
  localparam addr_t ADDR_MODE        = 'd0;
  localparam addr_t ADDR_DIRECT      = 'd1;
  localparam addr_t ADDR_STATUS      = 'd2;   // read only
  localparam addr_t ADDR_PRECHARGE   = 'd3;
  localparam addr_t ADDR_APERTURE    = 'd4;
  localparam addr_t ADDR_SEQ_N       = 'd5;
  localparam addr_t ADDR_SEQ0        = 'd6;
  localparam addr_t ADDR_SEQ1        = 'd7;
  localparam addr_t ADDR_SEQ2        = 'd8;
  localparam addr_t ADDR_SEQ3        = 'd9;
  localparam addr_t ADDR_SAMPLE_LAST = 'd10;  // read only, read clears irq

  // pin source select, 4..7 park everything low
  typedef enum logic [2:0] {
    MODE_DIRECT  = 3'd0,
    MODE_LO      = 3'd1,
    MODE_HI      = 3'd2,
    MODE_AZ_TEST = 3'd3
  } mode_e;

  // board pins, msb first, direct register maps bit for bit
  typedef struct packed {
    logic       spi_interrupt;
    logic       meas_complete;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } pin_vec_t;

endpackage

`default_nettype wire

/* include/dmm_settings.svh */
// width, count and magic constants for the dmm control core, included by packages and rtl
`ifndef DMM_SETTINGS_SVH
`define DMM_SETTINGS_SVH

`define DMM_REG_W         32      // spi register width
`define DMM_ADDR_W        8       // address field, msb is the write flag
`define DMM_CNT_W         24      // precharge and aperture counters

`define DMM_SEQ_MAX       4       // sequence table depth
`define DMM_PIN_W         20      // board pin vector

// low byte of status, lets the host see the link is alive
`define DMM_STATUS_MAGIC  8'hAA

`define DMM_SPI_BITS      40      // address byte plus one data word

`endif
